// ==== verilog/rv_consts.svh ====
// rv32i subset constants: widths, opcodes, funct3 codes and the reset pc
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`default_nettype none

// widths
`define XLEN      32
`define REG_AW    5
`define IMEM_AW   10
`define DMEM_AW   10

// major opcodes
`define OP_RTYPE  7'b0110011
`define OP_ITYPE  7'b0010011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011

// funct3 codes
`define F3_ADD    3'b000
`define F3_SLT    3'b010
`define F3_OR     3'b110
`define F3_AND    3'b111
`define F3_BEQ    3'b000
`define F3_BNE    3'b001

`define RESET_PC  10'd0

`default_nettype wire
`endif

// ==== verilog/rv_pkg.sv ====
// shared pipeline types for the five-stage rv32i subset core
`include "rv_consts.svh"
`default_nettype none

package rv_pkg;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_e;

    // --------------------
    // instruction word views
    typedef struct packed {
        logic [6:0]         funct7;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [`REG_AW-1:0] rd;
        logic [6:0]         opcode;
    } r_fmt_t;

    // i, s and b formats share this split
    typedef struct packed {
        logic [6:0]         imm_hi;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [4:0]         imm_lo;
        logic [6:0]         opcode;
    } is_fmt_t;

    typedef union packed {
        r_fmt_t  r_fmt;
        is_fmt_t is_fmt;
    } instr_u;

    // --------------------
    // stage registers
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t              ctrl;
        logic [`REG_AW-1:0] rs1;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   rs1_data;
        logic [`XLEN-1:0]   rs2_data;
        logic [`XLEN-1:0]   imm;
    } id_ex_t;

    typedef struct packed {
        logic               reg_write;
        logic               mem_read;
        logic               mem_write;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   alu_result;
        logic [`XLEN-1:0]   store_data;
    } ex_mem_t;

    // committed register write, also the last forwarding source
    typedef struct packed {
        logic               reg_write;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   wdata;
    } wb_t;

    typedef struct packed {
        logic                req;
        logic                we;
        logic [`DMEM_AW-1:0] addr;
        logic [`XLEN-1:0]    wdata;
    } dmem_req_t;

endpackage

`default_nettype wire

// ==== verilog/rv_fetch.sv ====
// instruction fetch stage: program counter and IF/ID register
`include "rv_consts.svh"
`default_nettype none

module rv_fetch import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                hazard_stall,
    input  logic                mem_stall,
    input  logic                branch_taken,
    input  logic [`IMEM_AW-1:0] branch_target,
    input  instr_u              imem_rdata,
    output logic [`IMEM_AW-1:0] imem_addr,
    output instr_u              instr,
    output logic [`IMEM_AW-1:0] pc
);

    logic [`IMEM_AW-1:0] pc_q;
    logic [`IMEM_AW-1:0] pc_next;
    logic                hold;

    // either stall freezes pc and IF/ID
    assign hold      = hazard_stall | mem_stall;
    assign imem_addr = pc_q;

    always_comb begin
        if (branch_taken) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc_q + 1'b1;
        end
    end

    // --------------------
    // pc and IF/ID
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q  <= `RESET_PC;
            instr <= '0;
            pc    <= '0;
        end else if (!hold) begin
            pc_q <= pc_next;
            pc   <= pc_q;
            // word fetched behind a taken branch becomes a bubble
            if (branch_taken) begin
                instr <= '0;
            end else begin
                instr <= imem_rdata;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rv_decode.sv ====
// decode stage: control, immediates, register file, hazards, branch resolve, ID/EX
`include "rv_consts.svh"
`default_nettype none

module rv_decode import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  instr_u              instr,
    input  logic [`IMEM_AW-1:0] pc,
    input  logic                mem_stall,
    input  ex_mem_t             ex_mem,
    input  wb_t                 wb,
    output id_ex_t              id_ex,
    output logic                hazard_stall,
    output logic                branch_taken,
    output logic [`IMEM_AW-1:0] branch_target
);

    logic [`XLEN-1:0]   regs [1:31];
    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic               is_r, is_i, is_ld, is_st, is_br;
    logic               use_rs1, use_rs2;
    ctrl_t              ctrl;
    logic [`XLEN-1:0]   imm;
    logic [`XLEN-1:0]   rf_a, rf_b;
    logic [`XLEN-1:0]   br_a, br_b;
    logic               ex_hit1, ex_hit2, ld_hit1, ld_hit2;
    logic               load_use, br_hazard;

    // read with write-first bypass from the committed write
    function automatic logic [`XLEN-1:0] rf_read(input logic [`REG_AW-1:0] idx);
        if (idx == '0) begin
            return '0;
        end else if (wb.reg_write && wb.rd == idx) begin
            return wb.wdata;
        end
        return regs[idx];
    endfunction

    function automatic alu_op_e f3_to_op(input logic [2:0] f3, input logic sub);
        case (f3)
            `F3_ADD: return sub ? alu_sub : alu_add;
            `F3_SLT: return alu_slt;
            `F3_OR:  return alu_or;
            `F3_AND: return alu_and;
            default: return alu_add;
        endcase
    endfunction

    assign rs1     = instr.r_fmt.rs1;
    assign rs2     = instr.r_fmt.rs2;
    assign opcode  = instr.r_fmt.opcode;
    assign funct3  = instr.r_fmt.funct3;
    assign is_r    = opcode == `OP_RTYPE;
    assign is_i    = opcode == `OP_ITYPE;
    assign is_ld   = opcode == `OP_LOAD;
    assign is_st   = opcode == `OP_STORE;
    assign is_br   = opcode == `OP_BRANCH;
    assign use_rs1 = is_r | is_i | is_ld | is_st | is_br;
    assign use_rs2 = is_r | is_st | is_br;

    always_comb begin
        ctrl = '0;
        if (is_r) begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_op    = f3_to_op(funct3, instr.r_fmt.funct7[5]);
        end else if (is_i) begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_src   = 1'b1;
            ctrl.alu_op    = f3_to_op(funct3, 1'b0);
        end else if (is_ld) begin
            ctrl.reg_write = 1'b1;
            ctrl.mem_read  = 1'b1;
            ctrl.alu_src   = 1'b1;
        end else if (is_st) begin
            ctrl.mem_write = 1'b1;
            ctrl.alu_src   = 1'b1;
        end
    end

    // sign-extended immediate from the i/s/b view
    always_comb begin
        if (is_st) begin
            imm = {{20{instr.is_fmt.imm_hi[6]}}, instr.is_fmt.imm_hi, instr.is_fmt.imm_lo};
        end else if (is_br) begin
            imm = {{19{instr.is_fmt.imm_hi[6]}}, instr.is_fmt.imm_hi[6],
                   instr.is_fmt.imm_lo[0], instr.is_fmt.imm_hi[5:0],
                   instr.is_fmt.imm_lo[4:1], 1'b0};
        end else begin
            imm = {{20{instr.is_fmt.imm_hi[6]}}, instr.is_fmt.imm_hi, instr.is_fmt.rs2};
        end
    end

    always_comb begin
        rf_a = rf_read(rs1);
        rf_b = rf_read(rs2);
    end

    // --------------------
    // hazards
    assign ex_hit1 = id_ex.ctrl.reg_write && id_ex.rd != '0 && id_ex.rd == rs1 && use_rs1;
    assign ex_hit2 = id_ex.ctrl.reg_write && id_ex.rd != '0 && id_ex.rd == rs2 && use_rs2;
    assign ld_hit1 = ex_mem.mem_read && ex_mem.rd != '0 && ex_mem.rd == rs1;
    assign ld_hit2 = ex_mem.mem_read && ex_mem.rd != '0 && ex_mem.rd == rs2;

    assign load_use     = id_ex.ctrl.mem_read && (ex_hit1 || ex_hit2);
    assign br_hazard    = is_br && (ex_hit1 || ex_hit2 || ld_hit1 || ld_hit2);
    assign hazard_stall = load_use | br_hazard;

    // branch operands, alu result from MEM if it matches
    assign br_a = (ex_mem.reg_write && !ex_mem.mem_read && ex_mem.rd != '0 &&
                   ex_mem.rd == rs1) ? ex_mem.alu_result : rf_a;
    assign br_b = (ex_mem.reg_write && !ex_mem.mem_read && ex_mem.rd != '0 &&
                   ex_mem.rd == rs2) ? ex_mem.alu_result : rf_b;

    assign branch_taken  = is_br && !br_hazard &&
                           ((funct3 == `F3_BEQ && br_a == br_b) ||
                            (funct3 == `F3_BNE && br_a != br_b));
    assign branch_target = pc + imm[`IMEM_AW+1:2];

    // --------------------
    // register file and ID/EX
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write && wb.rd != '0) begin
            regs[wb.rd] <= wb.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (!mem_stall) begin
            if (hazard_stall) begin
                id_ex <= '0;
            end else begin
                id_ex.ctrl     <= ctrl;
                id_ex.rs1      <= rs1;
                id_ex.rs2      <= rs2;
                id_ex.rd       <= instr.r_fmt.rd;
                id_ex.rs1_data <= rf_a;
                id_ex.rs2_data <= rf_b;
                id_ex.imm      <= imm;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rv_execute.sv ====
// execute stage: operand forwarding, alu and EX/MEM register
`include "rv_consts.svh"
`default_nettype none

module rv_execute import rv_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  id_ex_t  id_ex,
    input  wb_t     wb,
    input  logic    mem_stall,
    output ex_mem_t ex_mem
);

    logic [`XLEN-1:0] fwd_a;
    logic [`XLEN-1:0] fwd_b;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] result;

    // EX/MEM wins over MEM/WB, x0 never forwarded
    function automatic logic [`XLEN-1:0] forward(
        input logic [`REG_AW-1:0] idx,
        input logic [`XLEN-1:0]   reg_val
    );
        if (idx == '0) begin
            return reg_val;
        end else if (ex_mem.reg_write && ex_mem.rd == idx) begin
            return ex_mem.alu_result;
        end else if (wb.reg_write && wb.rd == idx) begin
            return wb.wdata;
        end
        return reg_val;
    endfunction

    always_comb begin
        fwd_a = forward(id_ex.rs1, id_ex.rs1_data);
        fwd_b = forward(id_ex.rs2, id_ex.rs2_data);
    end

    assign op_b = id_ex.ctrl.alu_src ? id_ex.imm : fwd_b;

    // --------------------
    // alu
    always_comb begin
        case (id_ex.ctrl.alu_op)
            alu_sub: result = fwd_a - op_b;
            alu_and: result = fwd_a & op_b;
            alu_or:  result = fwd_a | op_b;
            alu_slt: result = {31'd0, $signed(fwd_a) < $signed(op_b)};
            default: result = fwd_a + op_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (!mem_stall) begin
            ex_mem.reg_write  <= id_ex.ctrl.reg_write;
            ex_mem.mem_read   <= id_ex.ctrl.mem_read;
            ex_mem.mem_write  <= id_ex.ctrl.mem_write;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.alu_result <= result;
            // store data sees the same forwarding as operand b
            ex_mem.store_data <= fwd_b;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rv_memory.sv ====
// memory stage: data memory request, back-pressure and MEM/WB register
`include "rv_consts.svh"
`default_nettype none

module rv_memory import rv_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  ex_mem_t          ex_mem,
    input  logic [`XLEN-1:0] dmem_rdata,
    input  logic             dmem_ready,
    output dmem_req_t        dmem,
    output logic             mem_stall,
    output wb_t              wb
);

    logic [`XLEN-1:0] wdata_sel;

    // request fields come straight from EX/MEM, so they hold while stalled
    always_comb begin
        dmem.req   = ex_mem.mem_read | ex_mem.mem_write;
        dmem.we    = ex_mem.mem_write;
        dmem.addr  = ex_mem.alu_result[`DMEM_AW+1:2];
        dmem.wdata = ex_mem.store_data;
    end

    assign mem_stall = dmem.req & ~dmem_ready;

    // load data is valid in the ready cycle
    assign wdata_sel = ex_mem.mem_read ? dmem_rdata : ex_mem.alu_result;

    // --------------------
    // MEM/WB
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb <= '0;
        end else if (!mem_stall) begin
            wb.reg_write <= ex_mem.reg_write;
            wb.rd        <= ex_mem.rd;
            wb.wdata     <= wdata_sel;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rv_core.sv ====
// five-stage rv32i subset pipeline top level
`include "rv_consts.svh"
`default_nettype none

module rv_core import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [`XLEN-1:0]    imem_rdata,
    input  logic [`XLEN-1:0]    dmem_rdata,
    input  logic                dmem_ready,
    output logic [`IMEM_AW-1:0] imem_addr,
    output dmem_req_t           dmem
);

    instr_u              instr;
    logic [`IMEM_AW-1:0] pc;
    logic [`IMEM_AW-1:0] branch_target;
    logic                branch_taken;
    logic                hazard_stall;
    logic                mem_stall;
    id_ex_t              id_ex;
    ex_mem_t             ex_mem;
    wb_t                 wb;

    rv_fetch u_fetch (
        .clk(clk), .rst_n(rst_n), .hazard_stall(hazard_stall), .mem_stall(mem_stall),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .imem_rdata(imem_rdata), .imem_addr(imem_addr), .instr(instr), .pc(pc)
    );

    rv_decode u_decode (
        .clk(clk), .rst_n(rst_n), .instr(instr), .pc(pc), .mem_stall(mem_stall),
        .ex_mem(ex_mem), .wb(wb), .id_ex(id_ex), .hazard_stall(hazard_stall),
        .branch_taken(branch_taken), .branch_target(branch_target)
    );

    rv_execute u_execute (
        .clk(clk), .rst_n(rst_n), .id_ex(id_ex), .wb(wb), .mem_stall(mem_stall),
        .ex_mem(ex_mem)
    );

    rv_memory u_memory (
        .clk(clk), .rst_n(rst_n), .ex_mem(ex_mem), .dmem_rdata(dmem_rdata),
        .dmem_ready(dmem_ready), .dmem(dmem), .mem_stall(mem_stall), .wb(wb)
    );

endmodule

`default_nettype wire

// ==== tb/rv_core_sva.sv ====
// data memory handshake assertions, bound to the core top level
`default_nettype none

module rv_core_sva import rv_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input dmem_req_t dmem,
    input logic      dmem_ready
);

    // --------------------
    // request holds until accepted
    stable_until_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        (dmem.req && !dmem_ready) |=> $stable(dmem)
    ) else $error("dmem request changed before ready");

    we_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        dmem.we |-> dmem.req
    ) else $error("dmem write enable without request");

    // reset clears the request one edge later
    idle_in_reset: assert property (
        @(posedge clk) !rst_n |=> !dmem.req
    ) else $error("dmem request during reset");

endmodule

bind rv_core rv_core_sva u_sva (
    .clk(clk), .rst_n(rst_n), .dmem(dmem), .dmem_ready(dmem_ready)
);

`default_nettype wire

// ==== tb/rv_core_tb.sv ====
// testbench for the pipelined rv32i subset core with random program, isa model and memory models
`include "rv_consts.svh"
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

    localparam int BODY_LEN = 56;
    localparam int HALT_PC  = 63;
    localparam int TIMEOUT  = 4000;

    logic                clk;
    logic                rst_n;
    logic [`IMEM_AW-1:0] imem_addr;
    logic [`XLEN-1:0]    imem_rdata;
    logic [`XLEN-1:0]    dmem_rdata;
    logic                dmem_ready = 1'b0;
    dmem_req_t           dmem;

    logic [31:0] imem [0:1023];
    logic [31:0] dmem_mem [0:1023];
    logic [31:0] model_mem [0:1023];
    logic [31:0] model_regs [0:31];
    logic [9:0]  exp_addr[$];
    logic [31:0] exp_data[$];
    int          n_stores = 0;
    int          errors = 0;
    int          delay_cnt;

    rv_core u_rv_core (
        .clk(clk), .rst_n(rst_n), .imem_rdata(imem_rdata), .dmem_rdata(dmem_rdata),
        .dmem_ready(dmem_ready), .imem_addr(imem_addr), .dmem(dmem)
    );

    // both memories answer combinationally on their address
    assign imem_rdata = imem[imem_addr];
    assign dmem_rdata = dmem_mem[dmem.addr];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s got %08h expected %08h", $time, what, got, exp);
            errors++;
        end
    endtask

    // --------------------
    // instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OP_RTYPE};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
    endfunction

    task automatic gen_program();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        int unsigned kind;
        int unsigned off;
        logic [2:0]  f3s [0:4];
        f3s = '{`F3_ADD, `F3_ADD, `F3_AND, `F3_OR, `F3_SLT};
        for (int i = 0; i < 1024; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < BODY_LEN; i++) begin
            rd   = 5'(1 + $urandom % 7);
            rs1  = 5'($urandom % 8);
            rs2  = 5'($urandom % 8);
            kind = $urandom % 10;
            off  = 2 + $urandom % 3;
            if (kind >= 8 && i + off > BODY_LEN) begin
                kind = 4;
            end
            case (kind)
                0, 1, 2, 3: begin
                    off = $urandom % 5;
                    imem[i] = enc_r((off == 1) ? 7'h20 : 7'h00, rs2, rs1, f3s[off], rd);
                end
                4, 5: imem[i] = enc_i(12'($urandom), rs1, `F3_ADD, rd, `OP_ITYPE);
                6: imem[i] = enc_i(12'(4 * ($urandom % 16)), 5'd0, 3'b010, rd, `OP_LOAD);
                7: imem[i] = enc_s(12'(4 * ($urandom % 16)), rs2, 5'd0);
                default: imem[i] = enc_b(13'(4 * off), rs2, rs1,
                                         (kind == 8) ? `F3_BEQ : `F3_BNE);
            endcase
        end
        // epilogue dumps x1..x7 to words 17..23
        for (int r = 1; r <= 7; r++) begin
            imem[BODY_LEN + r - 1] = enc_s(12'(4 * (16 + r)), 5'(r), 5'd0);
        end
        imem[HALT_PC] = enc_b(13'd0, 5'd0, 5'd0, `F3_BEQ);
    endtask

    // --------------------
    // isa model
    task automatic run_model();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ea;
        int          pc;
        int          steps;
        pc    = 0;
        steps = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        while (pc != HALT_PC && steps < 1000) begin
            w  = imem[pc];
            a  = model_regs[w[19:15]];
            b  = model_regs[w[24:20]];
            pc = pc + 1;
            case (w[6:0])
                `OP_RTYPE: begin
                    case (w[14:12])
                        `F3_ADD: model_regs[w[11:7]] = w[30] ? a - b : a + b;
                        `F3_SLT: model_regs[w[11:7]] = {31'd0, $signed(a) < $signed(b)};
                        `F3_OR:  model_regs[w[11:7]] = a | b;
                        default: model_regs[w[11:7]] = a & b;
                    endcase
                end
                `OP_ITYPE: model_regs[w[11:7]] = a + {{20{w[31]}}, w[31:20]};
                `OP_LOAD: begin
                    ea = a + {{20{w[31]}}, w[31:20]};
                    model_regs[w[11:7]] = model_mem[ea[11:2]];
                end
                `OP_STORE: begin
                    ea = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    model_mem[ea[11:2]] = b;
                    exp_addr.push_back(ea[11:2]);
                    exp_data.push_back(b);
                end
                default: begin
                    if ((w[14:12] == `F3_BEQ) == (a == b)) begin
                        pc = pc - 1 + ($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}) >>> 2);
                    end
                end
            endcase
            model_regs[0] = '0;
            steps++;
        end
    endtask

    // --------------------
    // data memory model and store monitor
    always @(posedge clk) begin : dmem_model
        int unsigned d;
        if (!rst_n) begin
            dmem_ready <= 1'b0;
            delay_cnt  <= 0;
        end else if (dmem.req && dmem_ready) begin
            if (dmem.we) begin
                dmem_mem[dmem.addr] <= dmem.wdata;
                if (n_stores < exp_addr.size()) begin
                    check_value("store addr", 32'(dmem.addr), 32'(exp_addr[n_stores]));
                    check_value("store data", dmem.wdata, exp_data[n_stores]);
                end else begin
                    $display("unexpected extra store at time %0t", $time);
                    errors++;
                end
                n_stores++;
            end
            d = $urandom % 4;
            delay_cnt  <= d;
            dmem_ready <= (d == 0);
        end else if (dmem.req) begin
            if (delay_cnt <= 1) begin
                dmem_ready <= 1'b1;
            end else begin
                delay_cnt <= delay_cnt - 1;
            end
        end
    end

    initial begin : main
        int cnt;
        logic [31:0] v;
        rst_n = 1'b0;
        void'($urandom(32'he7b2a38b));
        gen_program();
        for (int i = 0; i < 1024; i++) begin
            v = $urandom;
            dmem_mem[i] <= v;
            model_mem[i] = v;
        end
        run_model();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("req after reset", 32'(dmem.req), 32'd0);
        check_value("imem_addr after reset", 32'(imem_addr), 32'(`RESET_PC));
        cnt = 0;
        while (rst_n !== 1'b1 && cnt < TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (cnt >= TIMEOUT) begin
            $display("timeout waiting for reset release");
            errors++;
        end
        cnt = 0;
        while (n_stores < exp_addr.size() && cnt < TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (cnt >= TIMEOUT) begin
            $display("timeout waiting for stores, saw %0d of %0d", n_stores, exp_addr.size());
            errors++;
        end
        cnt = 0;
        @(negedge clk);
        while (imem_addr != HALT_PC && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (cnt >= TIMEOUT) begin
            $display("timeout waiting for the halt loop");
            errors++;
        end
        repeat (16) @(posedge clk);
        check_value("store count", 32'(n_stores), 32'(exp_addr.size()));
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_memory.sv
verilog/rv_core.sv
tb/rv_core_sva.sv
tb/rv_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -j 0 --assert -Wno-fatal \
    --top-module rv_core_tb -f flist.f -o sim_rv_core
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_rv_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
if ! grep -q "All tests passed!" "$LOG"; then
    echo "no pass line in $LOG"
    exit 1
fi
exit 0
